// File: gfx_demo.f
+incdir+.
gfx_pkg.sv
vga_pkg.sv
gfx_test_pattern.sv
gfx_framebuffer.sv
vga_timing.sv
gfx_vga.sv
gfx_demo.sv
tb_clk_gen.sv
tb_gfx_demo.sv

// File: gfx_demo.sv
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_demo import gfx_pkg::*; (
  input  logic                       clk,
  input  logic                       arst_n,
  output logic [`GFX_COLOR_BITS-1:0] vga_red,
  output logic [`GFX_COLOR_BITS-1:0] vga_grn,
  output logic [`GFX_COLOR_BITS-1:0] vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  // Draw stream from the pattern generator into the display engine.
  draw_t draw;
  logic  draw_valid;
  logic  draw_ready;

  gfx_test_pattern u_pattern (
    .clk        (clk),
    .arst_n     (arst_n),
    .draw_ready (draw_ready),
    .draw       (draw),
    .draw_valid (draw_valid),
    .draw_last  ()
  );

  gfx_vga u_vga (
    .clk        (clk),
    .arst_n     (arst_n),
    .draw       (draw),
    .draw_valid (draw_valid),
    .draw_ready (draw_ready),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

endmodule

// File: gfx_framebuffer.sv
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_framebuffer import gfx_pkg::*, vga_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  draw_t     draw,
  input  logic      draw_valid,
  output logic      draw_ready,
  input  logic      rd_en,
  input  scan_pos_t rd_pos,
  output pixel_t    rd_data
);

  localparam int AX_BITS = $clog2(`GFX_H_ACTIVE);
  localparam int AY_BITS = $clog2(`GFX_V_ACTIVE);

  logic [`GFX_PIXEL_BITS-1:0] mem [0:`GFX_V_ACTIVE-1][0:`GFX_H_ACTIVE-1];
  logic                       wr_en;

  // Scan-out owns the port whenever it reads, writes take the spare cycles.
  assign draw_ready = !rd_en;
  assign wr_en      = draw_valid && draw_ready;

  // One port, so a cycle does either a read or a write.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data.raw <= mem[rd_pos.y[AY_BITS-1:0]][rd_pos.x[AX_BITS-1:0]];
    end else if (wr_en) begin
      mem[draw.y[AY_BITS-1:0]][draw.x[AX_BITS-1:0]] <= draw.color.raw;
    end
  end

  // A write outside the stored area would alias onto another pixel.
  wr_range_a : assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |-> (draw.x < `GFX_X_BITS'(`GFX_H_ACTIVE)) && (draw.y < `GFX_Y_BITS'(`GFX_V_ACTIVE)))
    else $error("framebuffer write outside the active area");

endmodule

// File: gfx_params.svh
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// Raster geometry. Blanking comes first in each line and each frame.
`define GFX_H_ACTIVE 16
`define GFX_H_FRONT 2
`define GFX_H_SYNC 4
`define GFX_H_BACK 2

`define GFX_V_ACTIVE 12
`define GFX_V_FRONT 1
`define GFX_V_SYNC 2
`define GFX_V_BACK 1

// One pixel word holds three equal colour fields.
`define GFX_PIXEL_BITS 12
`define GFX_COLOR_BITS 4

// Counter widths, sized for the H and V totals (24 and 16).
`define GFX_X_BITS 5
`define GFX_Y_BITS 4

// Cycles from reset release to display enable.
`define GFX_ENABLE_DELAY 8

`endif

// File: gfx_pkg.sv
`include "gfx_params.svh"

package gfx_pkg;

  typedef struct packed {
    logic [`GFX_COLOR_BITS-1:0] red;
    logic [`GFX_COLOR_BITS-1:0] grn;
    logic [`GFX_COLOR_BITS-1:0] blu;
  } rgb_t;

  // The framebuffer stores the raw word, scan-out reads it as colour fields.
  typedef union packed {
    logic [`GFX_PIXEL_BITS-1:0] raw;
    rgb_t                       rgb;
  } pixel_t;

  // One pixel of the draw stream.
  typedef struct packed {
    logic [`GFX_X_BITS-1:0] x;
    logic [`GFX_Y_BITS-1:0] y;
    pixel_t                 color;
  } draw_t;

endpackage

// File: gfx_test_pattern.sv
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_test_pattern import gfx_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  draw_ready,
  output draw_t draw,
  output logic  draw_valid,
  output logic  draw_last
);

  localparam logic [`GFX_X_BITS-1:0] X_LAST = `GFX_X_BITS'(`GFX_H_ACTIVE - 1);
  localparam logic [`GFX_Y_BITS-1:0] Y_LAST = `GFX_Y_BITS'(`GFX_V_ACTIVE - 1);

  logic [`GFX_X_BITS-1:0] x_cnt;
  logic [`GFX_Y_BITS-1:0] y_cnt;
  logic                   done;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x_cnt      <= '0;
      y_cnt      <= '0;
      draw_valid <= 1'b0;
      done       <= 1'b0;
    end else if (!done) begin
      if (!draw_valid) begin
        draw_valid <= 1'b1; // First clock out of reset.
      end else if (draw_ready) begin
        if (draw_last) begin
          draw_valid <= 1'b0;
          done       <= 1'b1;
        end else if (x_cnt == X_LAST) begin
          x_cnt <= '0;
          y_cnt <= y_cnt + 1'b1;
        end else begin
          x_cnt <= x_cnt + 1'b1;
        end
      end
    end
  end

  assign draw_last = (x_cnt == X_LAST) && (y_cnt == Y_LAST);

  // The colour is built through the rgb view of the pixel word.
  always_comb begin
    draw.x             = x_cnt;
    draw.y             = y_cnt;
    draw.color.rgb.red = x_cnt[`GFX_COLOR_BITS-1:0];
    draw.color.rgb.grn = y_cnt[`GFX_COLOR_BITS-1:0];
    draw.color.rgb.blu = x_cnt[`GFX_COLOR_BITS-1:0] ^ y_cnt[`GFX_COLOR_BITS-1:0];
  end

  // A stalled pixel must not change before it is taken.
  draw_hold_a : assert property (@(posedge clk) disable iff (!arst_n)
    draw_valid && !draw_ready |=> $stable(draw))
    else $error("draw changed while stalled");

endmodule

// File: gfx_vga.sv
`timescale 1ns/1ps
`include "gfx_params.svh"

module gfx_vga import gfx_pkg::*, vga_pkg::*; (
  input  logic                       clk,
  input  logic                       arst_n,
  input  draw_t                      draw,
  input  logic                       draw_valid,
  output logic                       draw_ready,
  output logic [`GFX_COLOR_BITS-1:0] vga_red,
  output logic [`GFX_COLOR_BITS-1:0] vga_grn,
  output logic [`GFX_COLOR_BITS-1:0] vga_blu,
  output logic                       vga_hsync,
  output logic                       vga_vsync
);

  localparam int DLY_BITS = $clog2(`GFX_ENABLE_DELAY + 1);

  logic [DLY_BITS-1:0] en_cnt;
  logic                disp_en;
  scan_pos_t           pos;
  sync_t               sync;
  sync_t               sync_d;
  logic                rd_en;
  pixel_t              rd_data;

  // The draw side gets a head start before scan-out claims the port.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      en_cnt  <= '0;
      disp_en <= 1'b0;
    end else if (!disp_en) begin
      en_cnt <= en_cnt + 1'b1;
      if (en_cnt == DLY_BITS'(`GFX_ENABLE_DELAY - 1)) begin
        disp_en <= 1'b1;
      end
    end
  end

  vga_timing u_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .enable (disp_en),
    .pos    (pos),
    .sync   (sync)
  );

  assign rd_en = disp_en && sync.active;

  gfx_framebuffer u_fb (
    .clk        (clk),
    .arst_n     (arst_n),
    .draw       (draw),
    .draw_valid (draw_valid),
    .draw_ready (draw_ready),
    .rd_en      (rd_en),
    .rd_pos     (pos),
    .rd_data    (rd_data)
  );

  // Sync and active wait one cycle for the read data, then all leave together.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_d    <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
    end else begin
      sync_d    <= sync;
      vga_hsync <= sync_d.hsync;
      vga_vsync <= sync_d.vsync;
      vga_red   <= sync_d.active ? rd_data.rgb.red : '0;
      vga_grn   <= sync_d.active ? rd_data.rgb.grn : '0;
      vga_blu   <= sync_d.active ? rd_data.rgb.blu : '0;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_gfx_demo -f gfx_demo.f -o sim_gfx_demo
out=$(./obj_dir/sim_gfx_demo)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk; // 20 ns period.

endmodule

// File: tb_gfx_demo.sv
`timescale 1ns/1ps
`include "gfx_params.svh"

module tb_gfx_demo import gfx_pkg::*; ();

  localparam int H_BLANK    = `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int H_TOTAL    = H_BLANK + `GFX_H_ACTIVE;
  localparam int FIRST_LINE = `GFX_V_SYNC + `GFX_V_BACK; // Lines from vsync fall to row 0.
  localparam int FRAME      = H_TOTAL * (`GFX_V_FRONT + FIRST_LINE + `GFX_V_ACTIVE);

  typedef struct packed {
    int   frame;
    int   offset; // Cycles after the falling vsync edge.
    int   x;
    int   y;
    rgb_t exp;
  } sample_t;

  logic                       clk;
  logic                       arst_n;
  logic [`GFX_COLOR_BITS-1:0] vga_red;
  logic [`GFX_COLOR_BITS-1:0] vga_grn;
  logic [`GFX_COLOR_BITS-1:0] vga_blu;
  logic                       vga_hsync;
  logic                       vga_vsync;

  sample_t     tbl[$];
  rgb_t        seen [64];
  logic [31:0] rng;
  logic        prev_vs;
  logic        hung;
  int          frame;
  int          offset;
  int          errors;
  int          checks;
  int          passed;
  int          failed;
  int          per_frame;

  tb_clk_gen u_clk (.clk(clk));

  gfx_demo DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift(rng);
    return int'(rng % 32'(n));
  endfunction

  // Red follows x, green follows y, blue is their exclusive-or.
  function automatic rgb_t pattern_rgb(input int x, input int y);
    rgb_t c;
    c.red = `GFX_COLOR_BITS'(x);
    c.grn = `GFX_COLOR_BITS'(y);
    c.blu = `GFX_COLOR_BITS'(x ^ y);
    return c;
  endfunction

  function automatic void add_sample(input int f, input int off, input int x, input int y,
                                     input logic active);
    sample_t s;
    s.frame  = f;
    s.offset = off;
    s.x      = x;
    s.y      = y;
    s.exp    = active ? pattern_rgb(x, y) : '0;
    tbl.push_back(s);
  endfunction

  // Both frames use the same points, so their colours can be compared later.
  task automatic build_table();
    int xs [`GFX_V_ACTIVE];
    int hb [`GFX_V_ACTIVE];
    int vb_top;
    int vb_end;
    int line;
    int f;
    int y;
    rng    = 32'd33627;
    vb_top = rand_below(FIRST_LINE * H_TOTAL);
    vb_end = rand_below(H_TOTAL);
    for (y = 0; y < `GFX_V_ACTIVE; y++) begin
      xs[y] = rand_below(`GFX_H_ACTIVE);
      hb[y] = rand_below(H_BLANK);
    end
    for (f = 2; f <= 3; f++) begin
      add_sample(f, vb_top, -1, -1, 1'b0);
      for (y = 0; y < `GFX_V_ACTIVE; y++) begin
        line = (FIRST_LINE + y) * H_TOTAL;
        add_sample(f, line + hb[y], -1, y, 1'b0);
        add_sample(f, line + H_BLANK + xs[y], xs[y], y, 1'b1);
      end
      add_sample(f, (FIRST_LINE + `GFX_V_ACTIVE) * H_TOTAL + vb_end, -1, -1, 1'b0); // Front porch.
    end
    per_frame = tbl.size() / 2;
  endtask

  // Outputs are sampled on the falling edge, half a cycle clear of any update.
  task automatic step();
    @(negedge clk);
    if (prev_vs && !vga_vsync) begin
      frame++;
      offset = 0;
    end else begin
      offset++;
    end
    prev_vs = vga_vsync;
  endtask

  task automatic wait_frame(input int target, input int limit);
    int n;
    n = 0;
    while (!hung && frame < target) begin
      if (n == limit) begin
        $display("Timeout: frame %0d did not start within %0d cycles", target, limit);
        hung = 1'b1;
        errors++;
      end else begin
        step();
        n++;
      end
    end
  endtask

  task automatic wait_offset(input int f, input int target, input int limit);
    int n;
    n = 0;
    while (!hung && frame == f && offset < target) begin
      if (n == limit) begin
        $display("Timeout: offset %0d of frame %0d not reached in %0d cycles", target, f, limit);
        hung = 1'b1;
        errors++;
      end else begin
        step();
        n++;
      end
    end
    if (!hung && (frame != f || offset != target)) begin
      $display("Sample point at offset %0d of frame %0d was missed", target, f);
      errors++;
    end
  endtask

  task automatic check_idle(input string phase);
    checks++;
    assert (vga_hsync && vga_vsync && {vga_red, vga_grn, vga_blu} == '0)
      else begin
        $display("[ERROR] %0t: outputs not idle %s, hsync %b vsync %b rgb %h%h%h", $time,
                 phase, vga_hsync, vga_vsync, vga_red, vga_grn, vga_blu);
        errors++;
      end
  endtask

  task automatic check_sync_frame();
    int   n;
    int   last;
    logic exp_hs;
    logic exp_vs;
    n    = 0;
    last = -1;
    wait_frame(1, 2 * FRAME);
    while (!hung && frame == 1) begin
      if (n > FRAME) begin
        $display("Timeout: frame 1 did not end within %0d cycles", FRAME);
        hung = 1'b1;
        errors++;
      end else begin
        exp_hs = !((offset % H_TOTAL) >= `GFX_H_FRONT &&
                   (offset % H_TOTAL) < `GFX_H_FRONT + `GFX_H_SYNC);
        exp_vs = !((offset / H_TOTAL) < `GFX_V_SYNC);
        checks++;
        assert (vga_hsync == exp_hs && vga_vsync == exp_vs)
          else begin
            $display("[ERROR] %0t: offset %0d hsync %b vsync %b, expected %b %b", $time,
                     offset, vga_hsync, vga_vsync, exp_hs, exp_vs);
            errors++;
          end
        last = offset;
        step();
        n++;
      end
    end
    if (!hung) begin
      checks++;
      assert (last == FRAME - 1)
        else begin
          $display("[ERROR] %0t: frame lasted %0d cycles, expected %0d", $time, last + 1, FRAME);
          errors++;
        end
    end
  endtask

  task automatic run_frame(input int f);
    rgb_t got;
    int   i;
    for (i = 0; i < tbl.size(); i++) begin
      if (!hung && tbl[i].frame == f) begin
        wait_frame(f, 2 * FRAME);
        wait_offset(f, tbl[i].offset, FRAME);
        got     = {vga_red, vga_grn, vga_blu};
        seen[i] = got;
        checks++;
        assert (got == tbl[i].exp)
          else begin
            $display("[ERROR] %0t: frame %0d offset %0d x %0d y %0d rgb %h, expected %h", $time,
                     f, tbl[i].offset, tbl[i].x, tbl[i].y, got, tbl[i].exp);
            errors++;
          end
      end
    end
  endtask

  task automatic check_repeat();
    int i;
    for (i = 0; i < per_frame; i++) begin
      checks++;
      assert (seen[i] == seen[i + per_frame])
        else begin
          $display("[ERROR] %0t: offset %0d shows %h in frame 2 but %h in frame 3", $time,
                   tbl[i].offset, seen[i], seen[i + per_frame]);
          errors++;
        end
    end
  endtask

  task automatic report(input string name, input int err0);
    if (errors == err0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    int err0;
    int i;
    arst_n  = 1'b0;
    prev_vs = 1'b1;
    hung    = 1'b0;
    frame   = 0;
    offset  = 0;
    errors  = 0;
    checks  = 0;
    passed  = 0;
    failed  = 0;
    build_table();

    err0 = errors;
    for (i = 0; i < 16; i++) begin
      step();
      check_idle("in reset");
    end
    @(posedge clk);
    #2 arst_n = 1'b1;
    for (i = 0; i < `GFX_ENABLE_DELAY; i++) begin
      step();
      check_idle("after reset"); // Display is not enabled yet.
    end
    report("reset_idle", err0);

    if (!hung) begin
      err0 = errors;
      check_sync_frame();
      report("sync_timing", err0);
    end
    if (!hung) begin
      err0 = errors;
      run_frame(2);
      report("frame2_samples", err0);
    end
    if (!hung) begin
      err0 = errors;
      run_frame(3);
      report("frame3_samples", err0);
    end
    if (!hung) begin
      err0 = errors;
      check_repeat();
      report("frame_repeat", err0);
    end

    $display("%0d tests passed, %0d failed, %0d checks, %0d errors", passed, failed, checks,
             errors);
    if (hung || failed != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

// File: vga_pkg.sv
`include "gfx_params.svh"

package vga_pkg;

  // Raster position, in active-area coordinates while active is high.
  typedef struct packed {
    logic [`GFX_X_BITS-1:0] x;
    logic [`GFX_Y_BITS-1:0] y;
  } scan_pos_t;

  // Both syncs are active low.
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;
  } sync_t;

endpackage

// File: vga_timing.sv
`timescale 1ns/1ps
`include "gfx_params.svh"

module vga_timing import vga_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      enable,
  output scan_pos_t pos,
  output sync_t     sync
);

  localparam int H_BLANK = `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
  localparam int H_TOTAL = H_BLANK + `GFX_H_ACTIVE;
  localparam int V_BLANK = `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK;
  localparam int V_TOTAL = V_BLANK + `GFX_V_ACTIVE;

  localparam logic [`GFX_X_BITS-1:0] H_LAST   = `GFX_X_BITS'(H_TOTAL - 1);
  localparam logic [`GFX_X_BITS-1:0] HS_START = `GFX_X_BITS'(`GFX_H_FRONT);
  localparam logic [`GFX_X_BITS-1:0] HS_END   = `GFX_X_BITS'(`GFX_H_FRONT + `GFX_H_SYNC);
  localparam logic [`GFX_X_BITS-1:0] H_ACT    = `GFX_X_BITS'(H_BLANK);

  localparam logic [`GFX_Y_BITS-1:0] V_LAST   = `GFX_Y_BITS'(V_TOTAL - 1);
  localparam logic [`GFX_Y_BITS-1:0] VS_START = `GFX_Y_BITS'(`GFX_V_FRONT);
  localparam logic [`GFX_Y_BITS-1:0] VS_END   = `GFX_Y_BITS'(`GFX_V_FRONT + `GFX_V_SYNC);
  localparam logic [`GFX_Y_BITS-1:0] V_ACT    = `GFX_Y_BITS'(V_BLANK);

  logic [`GFX_X_BITS-1:0] h_cnt;
  logic [`GFX_Y_BITS-1:0] v_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (enable) begin
      if (h_cnt == H_LAST) begin
        h_cnt <= '0;
        if (v_cnt == V_LAST) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Each line and frame runs front porch, sync, back porch, then active.
  always_comb begin
    sync.hsync  = !((h_cnt >= HS_START) && (h_cnt < HS_END));
    sync.vsync  = !((v_cnt >= VS_START) && (v_cnt < VS_END));
    sync.active = (h_cnt >= H_ACT) && (v_cnt >= V_ACT);
    pos.x       = h_cnt - H_ACT; // Only meaningful while active.
    pos.y       = v_cnt - V_ACT;
  end

  // The horizontal sync pulse has a fixed width.
  hsync_width_a : assert property (@(posedge clk) disable iff (!arst_n || !enable)
    $fell(sync.hsync) |-> !sync.hsync [*`GFX_H_SYNC] ##1 sync.hsync)
    else $error("hsync pulse width wrong");

endmodule
